/* vector_io_top.f */
vector_io_pkg.sv
io_port_decoder.sv
ppi_mode0.sv
video_ctrl_regs.sv
palette_lookup.sv
vector_io_top.sv
tb_vector_io.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I/O port testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_vector_io \
	-f vector_io_top.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation clean"

/* vector_io_stim.txt */
# op fields in hex: W port data | R port expect | T retrace | K rowbits shift.ctrl.rus
# S rowselect | C scroll border_idx mode512 palette_addr | P idx border active rgb | E name
C 00 0 0 0
S FF
P 0 0 0 000
E reset_state
W 00 80
W 03 A5
W 02 3C
W 01 96
R 03 A5
R 02 3C
R 01 96
E ppi_readback
W 00 01
W 00 0E
R 01 17
W 00 07
W 00 08
R 01 0F
E portc_bsr
W 00 8A
K 21 5
R 02 DE
W 00 05
R 01 44
R 08 FF
E keyboard_in
W 00 80
W 03 40
W 02 15
C 40 5 1 0
S FF
T 1
W 03 FE
W 02 07
S 01
C 40 5 1 7
E retrace_steer
W 02 03
W 0C D3
W 02 07
W 0C 2E
W 02 0A
W 0C 7F
W 02 07
T 0
C FE 7 0 7
P 3 0 1 64C
P A 0 1 EE4
P 3 1 1 CA0
P A 0 0 000
E palette_rgb

/* tb_vector_io.sv */
`timescale 1ns/100ps
`default_nettype none

// Stim file driven testbench for the I/O port section
module tb_vector_io import vector_io_pkg::*; ();

	localparam int ACK_TIMEOUT = 20;	// Cycles
	localparam int RUN_LIMIT = 5000;	// Watchdog, cycles

	logic		clk24;
	logic		mreset;
	wb_req_t	wb_req;
	wb_rsp_t	wb_rsp;
	kbd_in_t	kbd;
	logic		retrace;
	color_idx_t	pix_idx;
	logic		border;
	logic		video_active;
	vid_ctrl_t	ctrl;
	io_data_t	kbd_rowselect;
	rgb_t		rgb;

	int		errors;		// Wrong values over the whole run
	int		test_errs;	// Wrong values in the running test
	int		tests_ok;
	int		tests_bad;
	logic	aborted;	// Run stopped early

	vector_io_top dut_i (
		.clk24, .mreset,
		.wb_req, .wb_rsp,
		.kbd,
		.retrace, .pix_idx, .border, .video_active,
		.ctrl, .kbd_rowselect, .rgb
	);

	initial begin
		clk24 = 1'b0;
		forever #50 clk24 = ~clk24;	// 100 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// Stepping and bus access
	//////////////////////////////////////////////////////////////////////

	// Next edge, then on to the drive point
	task automatic next_cycle();
		@(posedge clk24);
		#10;
	endtask

	task automatic bus_access(input logic we, input io_addr_t adr, input io_data_t wdat,
			output io_data_t rdat);
		int		waited;
		logic	acked;
		waited = 0;
		acked = 1'b0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		while (!acked && waited < ACK_TIMEOUT) begin
			next_cycle();
			waited++;
			acked = wb_rsp.ack;
		end
		rdat = wb_rsp.dat;	// Valid with ack
		if (acked) begin
			next_cycle();	// Request held through the ack edge
		end else begin
			$display("No ack from port %h within %0d cycles, run stopped",
				adr, ACK_TIMEOUT);
			aborted = 1'b1;
		end
		wb_req = '0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_data(input io_data_t got, input io_data_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED %0d ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_ctrl(input vid_ctrl_t got, input vid_ctrl_t exp);
		if (got !== exp) begin
			$display("FAILED %0d ns: ctrl scroll %h border %h mode512 %b pal %h, %s %h %h %b %h",
				$time, got.scroll, got.border_idx, got.mode512, got.palette_addr,
				"expected", exp.scroll, exp.border_idx, exp.mode512, exp.palette_addr);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_rgb(input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			$display("FAILED %0d ns: rgb %h %h %h, expected %h %h %h",
				$time, got.r, got.g, got.b, exp.r, exp.g, exp.b);
			errors++;
			test_errs++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stim file interpreter
	//////////////////////////////////////////////////////////////////////
	task automatic run_stim();
		int				fd;
		int				n;
		string			line;
		string			tname;
		byte			opc;
		io_addr_t		adr;
		io_data_t		dat;
		io_data_t		got;
		logic [3:0]		idx;
		logic [3:0]		paddr;
		logic			bit_a;
		logic			bit_b;
		logic [11:0]	rgb_word;
		fd = $fopen("vector_io_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open vector_io_stim.txt");
			aborted = 1'b1;
		end
		while (fd != 0 && !aborted && $fgets(line, fd) != 0) begin
			n = $sscanf(line, "%c", opc);
			case (opc)
				"W": begin
					n = $sscanf(line, "%c %h %h", opc, adr, dat);
					bus_access(1'b1, adr, dat, got);
				end
				"R": begin
					n = $sscanf(line, "%c %h %h", opc, adr, dat);
					bus_access(1'b0, adr, 8'h00, got);
					if (!aborted)
						check_data(got, dat, $sformatf("read of port %h", adr));
				end
				"T": begin
					n = $sscanf(line, "%c %h", opc, bit_a);
					next_cycle();	// Last control copy lands under the old retrace
					retrace = bit_a;
				end
				"K": begin
					n = $sscanf(line, "%c %h %h", opc, dat, idx);
					kbd.rowbits = dat;
					kbd.shift = idx[2];
					kbd.ctrl = idx[1];
					kbd.rus = idx[0];
				end
				"S": begin
					n = $sscanf(line, "%c %h", opc, dat);
					next_cycle();	// Control copy lags the PPI latch
					check_data(kbd_rowselect, dat, "kbd_rowselect");
				end
				"C": begin
					n = $sscanf(line, "%c %h %h %h %h", opc, dat, idx, bit_a, paddr);
					next_cycle();
					check_ctrl(ctrl, '{dat, idx, bit_a, paddr});
				end
				"P": begin
					n = $sscanf(line, "%c %h %h %h %h", opc, idx, bit_a, bit_b, rgb_word);
					pix_idx = idx;
					border = bit_a;
					video_active = bit_b;
					next_cycle();	// RAM read
					next_cycle();	// RGB register
					check_rgb(rgb, rgb_t'(rgb_word));
				end
				"E": begin
					n = $sscanf(line, "%c %s", opc, tname);
					if (test_errs == 0) begin
						tests_ok++;
						$display("%s: ok", tname);
					end else begin
						tests_bad++;
						$display("%s: %0d wrong value(s)", tname, test_errs);
					end
					test_errs = 0;
				end
				"#", " ", "\n": ;	// Comment or blank
				default: begin
					$display("Unknown stimulus line: %s", line);
					errors++;
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////
	initial begin
		mreset = 1'b1;
		wb_req = '0;
		kbd = '0;
		retrace = 1'b0;
		pix_idx = '0;
		border = 1'b0;
		video_active = 1'b0;
		errors = 0;
		test_errs = 0;
		tests_ok = 0;
		tests_bad = 0;
		aborted = 1'b0;
		repeat (3) @(posedge clk24);	// Reset over 3 edges
		#10;
		mreset = 1'b0;
		run_stim();
		$display("Tests: %0d ok, %0d with errors, %0d wrong values",
			tests_ok, tests_bad, errors);
		if (aborted || errors != 0 || tests_ok == 0) begin
			$display("test failed");
		end else begin
			$display("test passed");
		end
		$finish;
	end

	initial begin
		repeat (RUN_LIMIT) @(posedge clk24);
		$display("Simulation ran past %0d cycles without finishing", RUN_LIMIT);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vector_io_top.sv */
`timescale 1ns/100ps
`default_nettype none

// I/O ports of the machine, bus slave down to RGB
module vector_io_top import vector_io_pkg::*; (
	input  wire logic		clk24,
	input  wire logic		mreset,
	input  wire wb_req_t	wb_req,
	output wb_rsp_t			wb_rsp,
	input  wire kbd_in_t	kbd,
	input  wire logic		retrace,
	input  wire color_idx_t	pix_idx,
	input  wire logic		border,
	input  wire logic		video_active,
	output vid_ctrl_t		ctrl,
	output io_data_t		kbd_rowselect,
	output rgb_t			rgb
);

	logic		ppi_wr;
	logic		ppi_rd;
	logic [1:0]	ppi_reg;
	io_data_t	wr_data;
	io_data_t	ppi_rdata;
	logic		pal_wr;
	ppi_out_t	ppi_ports;	// PA, PB, PC latches
	logic		palette_we;
	color_t		palette_val;

	//////////////////////////////////////////////////////////////////////
	// Bus side
	//////////////////////////////////////////////////////////////////////
	io_port_decoder decoder_i (
		.clk24, .mreset,
		.wb_req, .wb_rsp,
		.ppi_wr, .ppi_rd, .ppi_reg, .wr_data,
		.ppi_rdata,
		.pal_wr
	);

	ppi_mode0 ppi_i (
		.clk24, .mreset,
		.wr(ppi_wr), .rd(ppi_rd), .reg_sel(ppi_reg), .wdata(wr_data),
		.rdata(ppi_rdata),
		.kbd,
		.ports(ppi_ports)
	);

	//////////////////////////////////////////////////////////////////////
	// Video side
	//////////////////////////////////////////////////////////////////////
	video_ctrl_regs ctrl_regs_i (
		.clk24, .mreset, .retrace,
		.ports(ppi_ports),
		.pal_wr, .pal_data(wr_data),
		.ctrl, .kbd_rowselect,
		.palette_we, .palette_val
	);

	palette_lookup palette_i (
		.clk24, .mreset,
		.ctrl, .retrace,
		.palette_we, .palette_val,
		.pix_idx, .border, .video_active,
		.rgb
	);

endmodule

`default_nettype wire

/* palette_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

// 16 entry palette, index in, 4-4-4 RGB out two clocks later
module palette_lookup import vector_io_pkg::*; (
	input  wire logic		clk24,
	input  wire logic		mreset,
	input  wire vid_ctrl_t	ctrl,
	input  wire logic		retrace,
	input  wire logic		palette_we,
	input  wire color_t		palette_val,
	input  wire color_idx_t	pix_idx,
	input  wire logic		border,
	input  wire logic		video_active,
	output rgb_t			rgb
);

	color_t		pal_mem [16];	// BBGGGRRR entries
	color_idx_t	ram_adr;
	color_t		entry_q;		// Registered read
	logic		active_q;		// Matches read latency

	//////////////////////////////////////////////////////////////////////
	// Address select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		if (retrace || palette_we)
			ram_adr = ctrl.palette_addr;	// Host owns the RAM
		else if (border)
			ram_adr = ctrl.border_idx;
		else
			ram_adr = pix_idx;
	end

	// Single port RAM, read during write
	always_ff @(posedge clk24) begin
		if (palette_we)
			pal_mem[ram_adr] <= palette_val;
		entry_q <= pal_mem[ram_adr];
	end

	//////////////////////////////////////////////////////////////////////
	// DAC register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk24) begin
		if (mreset)
			active_q <= 1'b0;
		else
			active_q <= video_active;
	end

	always_ff @(posedge clk24) begin
		if (mreset) begin
			rgb <= '0;
		end else if (!active_q) begin
			rgb <= '0;		// Blanked
		end else begin
			rgb.r <= {entry_q[2:0], 1'b0};
			rgb.g <= {entry_q[5:3], 1'b0};
			rgb.b <= {entry_q[7:6], 2'b00};	// Blue has two bits only
		end
	end

endmodule

`default_nettype wire

/* video_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

// PPI outputs split between video and keyboard by retrace
module video_ctrl_regs import vector_io_pkg::*; (
	input  wire logic		clk24,
	input  wire logic		mreset,
	input  wire logic		retrace,	// High during retrace
	input  wire ppi_out_t	ports,
	input  wire logic		pal_wr,
	input  wire io_data_t	pal_data,
	output vid_ctrl_t		ctrl,
	output io_data_t		kbd_rowselect,
	output logic			palette_we,
	output color_t			palette_val
);

	//////////////////////////////////////////////////////////////////////
	// Port A and B steering
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk24) begin
		if (mreset) begin
			ctrl <= '0;
			kbd_rowselect <= 8'hFF;		// No row selected
		end else if (retrace) begin
			// Keyboard scan and palette index during retrace
			kbd_rowselect <= ~ports.pa;
			ctrl.palette_addr <= ports.pb[3:0];
		end else begin
			ctrl.scroll <= ports.pa;
			ctrl.border_idx <= ports.pb[3:0];
			ctrl.mode512 <= ports.pb[4];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Palette value port
	//////////////////////////////////////////////////////////////////////

	// Byte held for the RAM write
	always_ff @(posedge clk24) begin
		if (pal_wr)
			palette_val <= pal_data;
	end

	always_ff @(posedge clk24) begin
		if (mreset)
			palette_we <= 1'b0;
		else
			palette_we <= pal_wr;	// One pulse per bus write
	end

	// Each bus write gives a single RAM write
	pal_we_single: assert property (@(posedge clk24) disable iff (mreset)
		palette_we |=> !palette_we);

endmodule

`default_nettype wire

/* ppi_mode0.sv */
`timescale 1ns/100ps
`default_nettype none

// 8255 style port chip, basic input/output only
module ppi_mode0 import vector_io_pkg::*; (
	input  wire logic		clk24,
	input  wire logic		mreset,
	input  wire logic		wr,
	input  wire logic		rd,
	input  wire logic [1:0]	reg_sel,	// 0 A, 1 B, 2 C, 3 control
	input  wire io_data_t	wdata,
	output io_data_t		rdata,
	input  wire kbd_in_t	kbd,
	output ppi_out_t		ports
);

	localparam logic [1:0] REG_PA = 2'd0;
	localparam logic [1:0] REG_PB = 2'd1;
	localparam logic [1:0] REG_PC = 2'd2;
	localparam logic [1:0] REG_CW = 2'd3;

	// Direction, 1 is input
	logic		pa_in;
	logic		pb_in;
	logic		pcu_in;		// Port C bits 7..4
	logic		pcl_in;		// Port C bits 3..0
	io_data_t	pb_pins;
	io_data_t	pc_pins;
	io_data_t	rd_mux;

	//////////////////////////////////////////////////////////////////////
	// Control word and latches
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk24) begin
		if (mreset) begin
			pa_in <= 1'b1;		// All ports start as inputs
			pb_in <= 1'b1;
			pcu_in <= 1'b1;
			pcl_in <= 1'b1;
			ports <= '0;
		end else if (wr) begin
			case (reg_sel)
				REG_PA: ports.pa <= wdata;
				REG_PB: ports.pb <= wdata;
				REG_PC: ports.pc <= wdata;
				REG_CW: begin
					if (wdata[7]) begin
						// Mode set, latches go back to zero
						pa_in <= wdata[4];
						pcu_in <= wdata[3];
						pb_in <= wdata[1];
						pcl_in <= wdata[0];
						ports <= '0;
					end else begin
						ports.pc[wdata[3:1]] <= wdata[0];	// Bit set/reset
					end
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pin side
	//////////////////////////////////////////////////////////////////////

	// Keyboard matrix is active low on the pins
	assign pb_pins = ~kbd.rowbits;

	always_comb begin
		pc_pins[7] = ~kbd.rus;
		pc_pins[6] = ~kbd.ctrl;
		pc_pins[5] = ~kbd.shift;
		pc_pins[4] = 1'b0;		// Tape input
		pc_pins[3:0] = 4'hF;	// Lower half floats high
	end

	// Latch where output, pins where input
	always_comb begin
		case (reg_sel)
			REG_PA: rd_mux = pa_in ? 8'hFF : ports.pa;
			REG_PB: rd_mux = pb_in ? pb_pins : ports.pb;
			REG_PC: begin
				rd_mux[7:4] = pcu_in ? pc_pins[7:4] : ports.pc[7:4];
				rd_mux[3:0] = pcl_in ? pc_pins[3:0] : ports.pc[3:0];
			end
			default: rd_mux = 8'hFF;	// Control word not readable
		endcase
	end

	assign rdata = rd ? rd_mux : 8'h00;

endmodule

`default_nettype wire

/* io_port_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

// Port space is 000xxxYY, bits 4..2 pick the device
module io_port_decoder import vector_io_pkg::*; (
	input  wire logic		clk24,
	input  wire logic		mreset,
	input  wire wb_req_t	wb_req,
	output wb_rsp_t			wb_rsp,
	output logic			ppi_wr,		// One cycle, on the ack cycle
	output logic			ppi_rd,		// One cycle, when request is seen
	output logic [1:0]		ppi_reg,
	output io_data_t		wr_data,
	input  wire io_data_t	ppi_rdata,
	output logic			pal_wr
);

	localparam logic [2:0] DEV_PPI = 3'b000;	// Internal VV55
	localparam logic [2:0] DEV_PAL = 3'b011;	// Palette value out

	wb_state_t	state;
	io_data_t	rdata_q;	// Registered read data
	logic		req_seen;
	logic [2:0]	dev;

	assign req_seen = wb_req.cyc && wb_req.stb;
	assign dev = wb_req.adr[4:2];

	//////////////////////////////////////////////////////////////////////
	// Bus handshake
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk24) begin
		if (mreset) begin
			state <= WB_IDLE;
		end else begin
			case (state)
				WB_IDLE: if (req_seen) state <= WB_ACK;
				WB_ACK: state <= WB_IDLE;	// Always back to idle after ack
				default: state <= WB_IDLE;
			endcase
		end
	end

	// Read data is captured on the way into WB_ACK
	always_ff @(posedge clk24) begin
		if (state == WB_IDLE && req_seen && !wb_req.we) begin
			if (dev == DEV_PPI)
				rdata_q <= ppi_rdata;
			else
				rdata_q <= 8'hFF;	// Timer, disk, joystick etc. not here
		end
	end

	assign wb_rsp.ack = (state == WB_ACK);
	assign wb_rsp.dat = rdata_q;

	//////////////////////////////////////////////////////////////////////
	// Device strobes
	//////////////////////////////////////////////////////////////////////

	// Inverted low bits, so port 03 is A and 00 is control
	assign ppi_reg = ~wb_req.adr[1:0];
	assign wr_data = wb_req.dat;	// Master holds it until ack

	assign ppi_rd = (state == WB_IDLE) && req_seen && !wb_req.we
		&& (dev == DEV_PPI);

	// Writes land on the edge closing the ack cycle
	assign ppi_wr = (state == WB_ACK) && wb_req.we && (dev == DEV_PPI);
	assign pal_wr = (state == WB_ACK) && wb_req.we && (dev == DEV_PAL);

	// Ack only answers a request seen the cycle before
	ack_follows_req: assert property (@(posedge clk24) disable iff (mreset)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

`default_nettype wire

/* vector_io_pkg.sv */
`default_nettype none

package vector_io_pkg;

	//////////////////////////////////////////////////////////////////////
	// Plain vector types
	//////////////////////////////////////////////////////////////////////
	typedef logic [7:0] io_addr_t;		// 8080 port address
	typedef logic [7:0] io_data_t;		// Port data byte
	typedef logic [3:0] color_idx_t;	// Palette index
	typedef logic [7:0] color_t;		// BBGGGRRR palette entry
	typedef logic [3:0] chan_t;			// One DAC channel

	//////////////////////////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////////////////////////

	// Wishbone classic request from the master
	typedef struct packed {
		logic		cyc;
		logic		stb;
		logic		we;
		io_addr_t	adr;
		io_data_t	dat;
	} wb_req_t;

	typedef struct packed {
		logic		ack;
		io_data_t	dat;	// Read data, valid with ack
	} wb_rsp_t;

	// PPI output latches
	typedef struct packed {
		io_data_t	pa;
		io_data_t	pb;
		io_data_t	pc;
	} ppi_out_t;

	// Keyboard side, active high
	typedef struct packed {
		io_data_t	rowbits;
		logic		shift;
		logic		ctrl;
		logic		rus;
	} kbd_in_t;

	typedef struct packed {
		io_data_t	scroll;			// Vertical scroll
		color_idx_t	border_idx;
		logic		mode512;		// 512 pixel mode
		color_idx_t	palette_addr;	// Entry written during retrace
	} vid_ctrl_t;

	typedef struct packed {
		chan_t	r;
		chan_t	g;
		chan_t	b;
	} rgb_t;

	// Bus slave states
	typedef enum logic {
		WB_IDLE,
		WB_ACK
	} wb_state_t;

endpackage

`default_nettype wire
